// ==== hdl/video_acc_pkg.sv ====
package video_acc_pkg;

   // Widths of the instruction, data and address paths
   localparam int INST_W      = 32;
   localparam int DATA_W      = 64;
   localparam int ADDR_W      = 64;
   localparam int LEN_W       = 13;
   localparam int WORD_BYTES  = DATA_W / 8;
   localparam int WORD_SHIFT  = $clog2(WORD_BYTES);
   localparam int BLOCK_SHIFT = 6;

   typedef logic [INST_W-1:0] inst_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [LEN_W-1:0]  len_t;

   // Transfer size in data words, wide enough for the largest length
   localparam int WORDS_W = $bits(len_t) - WORD_SHIFT;
   typedef logic [WORDS_W-1:0] words_t;

   typedef enum logic [5:0] {
      OP_NOP       = 6'd0,
      OP_MOV       = 6'd1,
      OP_LOAD_FULL = 6'd2,
      OP_LOAD_LOW  = 6'd3
   } opcode_t;

   // Attribute values selecting the base address a load writes
   localparam logic [4:0] ATTR_RD_BASE = 5'd0;
   localparam logic [4:0] ATTR_WR_BASE = 5'd1;

   // Instruction field positions
   localparam int OP_LSB   = 0;
   localparam int OP_MSB   = 5;
   localparam int SRC_LSB  = 6;
   localparam int SRC_MSB  = 12;
   localparam int DST_LSB  = 13;
   localparam int DST_MSB  = 19;
   localparam int LEN_LSB  = 20;
   localparam int LEN_MSB  = 26;
   localparam int ATTR_LSB = 27;
   localparam int ATTR_MSB = 31;

   // Base address bits replaced by LOAD_LOW
   localparam int LOW_LSB = 6;
   localparam int LOW_MSB = 26;

endpackage

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int  DEPTH     = 8
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t head,
   output logic     empty,
   output logic     full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;
   assign empty   = (count == '0);
   assign full    = (count == CNT_W'(DEPTH));

   // Show-ahead output, the oldest entry is always visible
   assign head = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder import video_acc_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  inst_t  inst_head,
   input  logic   inst_empty,
   output logic   inst_pop,
   output logic   start,
   output addr_t  rd_addr,
   output addr_t  wr_addr,
   output words_t xfer_words,
   input  logic   xfer_done
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_FULL_LOW,
      ST_FULL_HIGH,
      ST_LAUNCH,
      ST_WAIT
   } state_t;

   // Clears the sub-block bits of a LOAD_FULL low word
   localparam inst_t ALIGN_MASK = inst_t'((1 << BLOCK_SHIFT) - 1);

   state_t     state;
   addr_t      base_rd;
   addr_t      base_wr;
   logic [4:0] load_attr;
   logic       retire;

   opcode_t    op;
   logic [4:0] attr;
   addr_t      src_off;
   addr_t      dst_off;
   len_t       len_bytes;

   // Field decode of the instruction at the FIFO head
   assign op        = opcode_t'(inst_head[OP_MSB:OP_LSB]);
   assign attr      = inst_head[ATTR_MSB:ATTR_LSB];
   assign src_off   = addr_t'(inst_head[SRC_MSB:SRC_LSB]) << BLOCK_SHIFT;
   assign dst_off   = addr_t'(inst_head[DST_MSB:DST_LSB]) << BLOCK_SHIFT;
   assign len_bytes = len_t'(inst_head[LEN_MSB:LEN_LSB]) << BLOCK_SHIFT;

   assign start = (state == ST_LAUNCH);

   always_comb begin
      inst_pop = 1'b0;
      case (state)
         ST_IDLE: begin
            if (!inst_empty) begin
               case (op)
                  // A MOV stays at the head until its transfer is written
                  OP_MOV: inst_pop = (len_bytes == '0);
                  // Loads, NOP and unknown opcodes leave at once
                  default: inst_pop = 1'b1;
               endcase
            end
         end
         ST_FULL_LOW, ST_FULL_HIGH: inst_pop = !inst_empty;
         ST_WAIT: inst_pop = retire;
         default: inst_pop = 1'b0;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= ST_IDLE;
         base_rd   <= '0;
         base_wr   <= '0;
         load_attr <= '0;
         retire    <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (!inst_empty) begin
                  case (op)
                     OP_MOV: begin
                        if (len_bytes != '0) begin
                           state <= ST_LAUNCH;
                        end
                     end
                     OP_LOAD_FULL: begin
                        load_attr <= attr;
                        state     <= ST_FULL_LOW;
                     end
                     OP_LOAD_LOW: begin
                        if (attr == ATTR_RD_BASE) begin
                           base_rd[LOW_MSB:LOW_LSB] <= inst_head[LOW_MSB:LOW_LSB];
                        end else if (attr == ATTR_WR_BASE) begin
                           base_wr[LOW_MSB:LOW_LSB] <= inst_head[LOW_MSB:LOW_LSB];
                        end
                     end
                     default: ;
                  endcase
               end
            end
            ST_FULL_LOW: begin
               if (!inst_empty) begin
                  if (load_attr == ATTR_RD_BASE) begin
                     base_rd[INST_W-1:0] <= inst_head & ~ALIGN_MASK;
                  end else if (load_attr == ATTR_WR_BASE) begin
                     base_wr[INST_W-1:0] <= inst_head & ~ALIGN_MASK;
                  end
                  state <= ST_FULL_HIGH;
               end
            end
            ST_FULL_HIGH: begin
               if (!inst_empty) begin
                  if (load_attr == ATTR_RD_BASE) begin
                     base_rd[ADDR_W-1:INST_W] <= inst_head;
                  end else if (load_attr == ATTR_WR_BASE) begin
                     base_wr[ADDR_W-1:INST_W] <= inst_head;
                  end
                  state <= ST_IDLE;
               end
            end
            ST_LAUNCH: begin
               retire <= 1'b0;
               state  <= ST_WAIT;
            end
            ST_WAIT: begin
               // Pop one cycle after the write mover reports the last word
               if (retire) begin
                  retire <= 1'b0;
                  state  <= ST_IDLE;
               end else if (xfer_done) begin
                  retire <= 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Transfer parameters latched when a MOV is seen
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && !inst_empty && op == OP_MOV) begin
         rd_addr    <= base_rd + src_off;
         wr_addr    <= base_wr + dst_off;
         xfer_words <= words_t'(len_bytes >> WORD_SHIFT);
      end
   end

endmodule

// ==== hdl/mem_read_mover.sv ====
`timescale 1ns/1ns

module mem_read_mover import video_acc_pkg::*; #(
   parameter int DATA_DEPTH = 16
) (
   input  logic   clk,
   input  logic   rst,
   input  logic   start,
   input  addr_t  rd_addr,
   input  words_t xfer_words,
   input  logic   buf_pop,
   output logic   mem_rd_en,
   output addr_t  mem_rd_addr
);

   localparam int CREDIT_W = $clog2(DATA_DEPTH + 1);

   addr_t               next_addr;
   words_t              remaining;
   logic [CREDIT_W-1:0] credit;
   logic                issue;

   // Credit counts free buffer slots not yet claimed by an outstanding read
   assign issue       = (remaining != '0) && (credit != '0);
   assign mem_rd_en   = issue;
   assign mem_rd_addr = next_addr;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         remaining <= '0;
         credit    <= CREDIT_W'(DATA_DEPTH);
      end else begin
         if (start) begin
            remaining <= xfer_words;
         end else if (issue) begin
            remaining <= remaining - 1'b1;
         end

         case ({issue, buf_pop})
            2'b10: credit <= credit - 1'b1;
            2'b01: credit <= credit + 1'b1;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         next_addr <= rd_addr;
      end else if (issue) begin
         next_addr <= next_addr + addr_t'(WORD_BYTES);
      end
   end

endmodule

// ==== hdl/mem_write_mover.sv ====
`timescale 1ns/1ns

module mem_write_mover import video_acc_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   start,
   input  addr_t  wr_addr,
   input  words_t xfer_words,
   input  data_t  buf_head,
   input  logic   buf_empty,
   output logic   buf_pop,
   output logic   mem_wr_en,
   output addr_t  mem_wr_addr,
   output data_t  mem_wr_data,
   input  logic   mem_wr_ready,
   output logic   xfer_done
);

   addr_t  addr_q;
   words_t remaining;

   // Head of the buffer is held until memory accepts it
   assign mem_wr_en   = !buf_empty;
   assign mem_wr_addr = addr_q;
   assign mem_wr_data = buf_head;
   assign buf_pop     = mem_wr_en && mem_wr_ready;

   // Last word of the transfer accepted
   assign xfer_done = buf_pop && (remaining == words_t'(1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         remaining <= '0;
      end else if (start) begin
         remaining <= xfer_words;
      end else if (buf_pop) begin
         remaining <= remaining - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         addr_q <= wr_addr;
      end else if (buf_pop) begin
         addr_q <= addr_q + addr_t'(WORD_BYTES);
      end
   end

endmodule

// ==== hdl/video_acc.sv ====
`timescale 1ns/1ns

module video_acc import video_acc_pkg::*; #(
   parameter int INST_DEPTH = 8,
   parameter int DATA_DEPTH = 16
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  inst_wr_en,
   input  inst_t inst_wr_data,
   output logic  inst_full,
   output logic  mem_rd_en,
   output addr_t mem_rd_addr,
   input  logic  mem_rd_valid,
   input  data_t mem_rd_data,
   output logic  mem_wr_en,
   output addr_t mem_wr_addr,
   output data_t mem_wr_data,
   input  logic  mem_wr_ready,
   output logic  cmd_done
);

   inst_t  inst_head;
   logic   inst_empty;
   logic   inst_pop;
   logic   start;
   addr_t  rd_addr;
   addr_t  wr_addr;
   words_t xfer_words;
   data_t  buf_head;
   logic   buf_empty;
   logic   buf_pop;

   // Host instructions, dropped by the FIFO when it is full
   sync_fifo #(
      .payload_t (inst_t),
      .DEPTH     (INST_DEPTH)
   ) inst_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (inst_wr_en),
      .push_data (inst_wr_data),
      .pop       (inst_pop),
      .head      (inst_head),
      .empty     (inst_empty),
      .full      (inst_full)
   );

   inst_decoder decoder (
      .clk        (clk),
      .rst        (rst),
      .inst_head  (inst_head),
      .inst_empty (inst_empty),
      .inst_pop   (inst_pop),
      .start      (start),
      .rd_addr    (rd_addr),
      .wr_addr    (wr_addr),
      .xfer_words (xfer_words),
      .xfer_done  (cmd_done)
   );

   mem_read_mover #(
      .DATA_DEPTH (DATA_DEPTH)
   ) rd_mover (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .rd_addr     (rd_addr),
      .xfer_words  (xfer_words),
      .buf_pop     (buf_pop),
      .mem_rd_en   (mem_rd_en),
      .mem_rd_addr (mem_rd_addr)
   );

   // Read data lands here directly, credit keeps it from overflowing
   sync_fifo #(
      .payload_t (data_t),
      .DEPTH     (DATA_DEPTH)
   ) data_buf (
      .clk       (clk),
      .rst       (rst),
      .push      (mem_rd_valid),
      .push_data (mem_rd_data),
      .pop       (buf_pop),
      .head      (buf_head),
      .empty     (buf_empty),
      .full      ()
   );

   mem_write_mover wr_mover (
      .clk          (clk),
      .rst          (rst),
      .start        (start),
      .wr_addr      (wr_addr),
      .xfer_words   (xfer_words),
      .buf_head     (buf_head),
      .buf_empty    (buf_empty),
      .buf_pop      (buf_pop),
      .mem_wr_en    (mem_wr_en),
      .mem_wr_addr  (mem_wr_addr),
      .mem_wr_data  (mem_wr_data),
      .mem_wr_ready (mem_wr_ready),
      .xfer_done    (cmd_done)
   );

endmodule

// ==== bench/tb_mem.sv ====
`timescale 1ns/1ns

module tb_mem import video_acc_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  mem_rd_en,
   input  addr_t mem_rd_addr,
   output logic  mem_rd_valid,
   output data_t mem_rd_data,
   input  logic  mem_wr_en,
   input  addr_t mem_wr_addr,
   input  data_t mem_wr_data,
   output logic  mem_wr_ready,
   input  addr_t peek_addr,
   output data_t peek_data
);

   integer seed;
   int     cycle;
   int     last_due;
   int     due;
   data_t  words [addr_t];
   int     due_q [$];
   data_t  data_q [$];

   // Locations never written read back as a pattern of their full address
   function automatic data_t fill_word(addr_t a);
      return {a[31:0] ^ 32'h9e37_79b9, a[63:32] ^ a[31:0]} ^ 64'hc3a5_0f96_7b1e_d248;
   endfunction

   function automatic data_t read_word(addr_t a);
      if (words.exists(a)) begin
         return words[a];
      end
      return fill_word(a);
   endfunction

   initial begin
      seed         = 72;
      cycle        = 0;
      last_due     = -1;
      mem_rd_valid = 1'b0;
      mem_rd_data  = '0;
      mem_wr_ready = 1'b0;
   end

   // Side port for the final memory compare
   always @(peek_addr) begin
      peek_data = read_word(peek_addr);
   end

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         mem_rd_valid <= 1'b0;
         mem_wr_ready <= 1'b0;
      end else begin
         cycle = cycle + 1;
         if (mem_wr_en && mem_wr_ready) begin
            words[mem_wr_addr] = mem_wr_data;
         end
         // Reads come back in order, 1 to 4 cycles after the strobe
         if (mem_rd_en) begin
            due = cycle + ($unsigned($random(seed)) % 4);
            if (due <= last_due) begin
               due = last_due + 1;
            end
            last_due = due;
            due_q.push_back(due);
            data_q.push_back(read_word(mem_rd_addr));
         end
         if (due_q.size() > 0 && due_q[0] == cycle) begin
            mem_rd_valid <= 1'b1;
            mem_rd_data  <= data_q.pop_front();
            void'(due_q.pop_front());
         end else begin
            mem_rd_valid <= 1'b0;
         end
         // Write back-pressure about one cycle in four
         mem_wr_ready <= (($random(seed) & 3) != 0);
      end
   end

endmodule

// ==== bench/video_acc_tb.sv ====
`timescale 1ns/1ns

module video_acc_tb import video_acc_pkg::*; ();

   localparam int INST_DEPTH  = 8;
   localparam int DATA_DEPTH  = 16;
   localparam int PROGRAMS    = 4;
   localparam int PROGRAM_LEN = 12;

   logic  clk;
   logic  rst;
   logic  inst_wr_en;
   inst_t inst_wr_data;
   logic  inst_full;
   logic  mem_rd_en;
   addr_t mem_rd_addr;
   logic  mem_rd_valid;
   data_t mem_rd_data;
   logic  mem_wr_en;
   addr_t mem_wr_addr;
   data_t mem_wr_data;
   logic  mem_wr_ready;
   logic  cmd_done;
   addr_t peek_addr;
   data_t peek_data;

   integer     seed;
   int         cycle_count;
   int         timeout_limit;
   int         done_count;
   int         exp_done;
   int         full_stage;
   logic [4:0] full_attr;
   addr_t      m_rd_base;
   addr_t      m_wr_base;
   data_t      model_mem [addr_t];
   addr_t      exp_rd_q [$];
   addr_t      exp_addr_q [$];
   data_t      exp_data_q [$];

   video_acc #(
      .INST_DEPTH (INST_DEPTH),
      .DATA_DEPTH (DATA_DEPTH)
   ) uut (
      .clk          (clk),
      .rst          (rst),
      .inst_wr_en   (inst_wr_en),
      .inst_wr_data (inst_wr_data),
      .inst_full    (inst_full),
      .mem_rd_en    (mem_rd_en),
      .mem_rd_addr  (mem_rd_addr),
      .mem_rd_valid (mem_rd_valid),
      .mem_rd_data  (mem_rd_data),
      .mem_wr_en    (mem_wr_en),
      .mem_wr_addr  (mem_wr_addr),
      .mem_wr_data  (mem_wr_data),
      .mem_wr_ready (mem_wr_ready),
      .cmd_done     (cmd_done)
   );

   tb_mem memory (
      .clk          (clk),
      .rst          (rst),
      .mem_rd_en    (mem_rd_en),
      .mem_rd_addr  (mem_rd_addr),
      .mem_rd_valid (mem_rd_valid),
      .mem_rd_data  (mem_rd_data),
      .mem_wr_en    (mem_wr_en),
      .mem_wr_addr  (mem_wr_addr),
      .mem_wr_data  (mem_wr_data),
      .mem_wr_ready (mem_wr_ready),
      .peek_addr    (peek_addr),
      .peek_data    (peek_data)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic abort_run();
      $display("test failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_data(data_t got, data_t exp, string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_addr(addr_t got, addr_t exp, string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(int got, int exp, string what);
      if (got != exp) begin
         $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_flag(logic got, logic exp, string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   function automatic int rand_below(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic data_t fill_word(addr_t a);
      return {a[31:0] ^ 32'h9e37_79b9, a[63:32] ^ a[31:0]} ^ 64'hc3a5_0f96_7b1e_d248;
   endfunction

   function automatic data_t model_word(addr_t a);
      if (model_mem.exists(a)) begin
         return model_mem[a];
      end
      return fill_word(a);
   endfunction

   function automatic inst_t make_inst(logic [5:0] op, logic [6:0] src, logic [6:0] dst,
                                       logic [6:0] len, logic [4:0] attr);
      inst_t w;
      w = '0;
      w[OP_MSB:OP_LSB]     = op;
      w[SRC_MSB:SRC_LSB]   = src;
      w[DST_MSB:DST_LSB]   = dst;
      w[LEN_MSB:LEN_LSB]   = len;
      w[ATTR_MSB:ATTR_LSB] = attr;
      return w;
   endfunction

   // Random payload bits under a fixed opcode and attribute
   function automatic inst_t rand_inst(logic [5:0] op, logic [4:0] attr);
      inst_t w;
      w = $random(seed);
      w[OP_MSB:OP_LSB]     = op;
      w[ATTR_MSB:ATTR_LSB] = attr;
      return w;
   endfunction

   // Read and write regions differ in bits 41:40 so that a copy never reads its own output
   function automatic addr_t region_base(logic [1:0] tag);
      addr_t b;
      b = {$random(seed), $random(seed)};
      b[41:40] = tag;
      return b;
   endfunction

   // Words written behind the held MOV whose tail falls on a full FIFO
   function automatic inst_t burst_word(int n);
      if (n >= INST_DEPTH - 1) begin
         return make_inst(OP_MOV, 7'd9, 7'(60 + n), 7'd3, 5'd0);
      end
      case (n % 4)
         0: return make_inst(OP_NOP, 7'd1, 7'd1, 7'd1, 5'd0);
         1: return make_inst(OP_MOV, 7'(n), 7'(20 + 4 * n), 7'd2, 5'd0);
         2: return make_inst(6'd45, 7'd2, 7'd3, 7'd4, 5'd1);
         default: return rand_inst(OP_LOAD_LOW, ATTR_RD_BASE);
      endcase
   endfunction

   // Reference model stepping one instruction word at a time in FIFO order
   task automatic model_step(inst_t w);
      logic [31:0] lo;
      addr_t       src;
      addr_t       dst;
      data_t       d;
      int          words;
      int          i;
      timeout_limit += 200;
      if (full_stage == 1) begin
         lo = w;
         lo[BLOCK_SHIFT-1:0] = '0;
         if (full_attr == ATTR_RD_BASE) begin
            m_rd_base[31:0] = lo;
         end else if (full_attr == ATTR_WR_BASE) begin
            m_wr_base[31:0] = lo;
         end
         full_stage = 2;
      end else if (full_stage == 2) begin
         if (full_attr == ATTR_RD_BASE) begin
            m_rd_base[63:32] = w;
         end else if (full_attr == ATTR_WR_BASE) begin
            m_wr_base[63:32] = w;
         end
         full_stage = 0;
      end else begin
         case (w[OP_MSB:OP_LSB])
            OP_LOAD_FULL: begin
               full_attr  = w[ATTR_MSB:ATTR_LSB];
               full_stage = 1;
            end
            OP_LOAD_LOW: begin
               if (w[ATTR_MSB:ATTR_LSB] == ATTR_RD_BASE) begin
                  m_rd_base[26:6] = w[26:6];
               end else if (w[ATTR_MSB:ATTR_LSB] == ATTR_WR_BASE) begin
                  m_wr_base[26:6] = w[26:6];
               end
            end
            OP_MOV: begin
               src   = m_rd_base + (addr_t'(w[SRC_MSB:SRC_LSB]) << BLOCK_SHIFT);
               dst   = m_wr_base + (addr_t'(w[DST_MSB:DST_LSB]) << BLOCK_SHIFT);
               words = (int'(w[LEN_MSB:LEN_LSB]) << BLOCK_SHIFT) / WORD_BYTES;
               for (i = 0; i < words; i++) begin
                  d = model_word(src + addr_t'(i * WORD_BYTES));
                  exp_rd_q.push_back(src + addr_t'(i * WORD_BYTES));
                  exp_addr_q.push_back(dst + addr_t'(i * WORD_BYTES));
                  exp_data_q.push_back(d);
                  model_mem[dst + addr_t'(i * WORD_BYTES)] = d;
               end
               if (words > 0) begin
                  exp_done++;
               end
               timeout_limit += 50 * words;
            end
            default: ;
         endcase
      end
   endtask

   // Writes one word once the FIFO has room
   task automatic write_inst(inst_t w);
      @(negedge clk);
      while (inst_full) begin
         @(negedge clk);
      end
      @(posedge clk);
      inst_wr_en   <= 1'b1;
      inst_wr_data <= w;
      @(posedge clk);
      inst_wr_en   <= 1'b0;
   endtask

   task automatic send(inst_t w);
      write_inst(w);
      model_step(w);
   endtask

   task automatic load_full(logic [4:0] attr, addr_t base);
      send(make_inst(OP_LOAD_FULL, 7'd0, 7'd0, 7'd0, attr));
      send(base[31:0]);
      send(base[63:32]);
   endtask

   task automatic send_random_inst();
      int         kind;
      logic [4:0] attr;
      kind = rand_below(8);
      attr = 5'(rand_below(4));
      case (kind)
         0: send(rand_inst(OP_NOP, 5'(rand_below(32))));
         1: send(rand_inst(6'(4 + rand_below(60)), 5'(rand_below(32))));
         2: send(rand_inst(OP_LOAD_LOW, attr));
         3: load_full(attr, region_base((attr == ATTR_RD_BASE) ? 2'b00 : 2'b10));
         default: send(make_inst(OP_MOV, 7'(rand_below(128)), 7'(rand_below(128)),
                                 7'(rand_below(16)), 5'(rand_below(32))));
      endcase
   endtask

   task automatic wait_idle();
      while (exp_addr_q.size() != 0) begin
         @(negedge clk);
      end
      // The MOV leaves the FIFO the cycle after its done pulse
      repeat (2) @(negedge clk);
      check_count(done_count, exp_done, "completed commands");
   endtask

   // Every read strobe and accepted memory write is checked against the model
   always @(posedge clk) begin
      if (!rst && mem_rd_en) begin
         if (exp_rd_q.size() == 0) begin
            $display("Memory read from %h at %0t with no copy outstanding",
                     mem_rd_addr, $time);
            abort_run();
         end else begin
            check_addr(mem_rd_addr, exp_rd_q.pop_front(), "read address");
         end
      end
      if (!rst && mem_wr_en && mem_wr_ready) begin
         if (exp_addr_q.size() == 0) begin
            $display("Memory write to %h at %0t with no copy outstanding", mem_wr_addr, $time);
            abort_run();
         end else begin
            check_addr(mem_wr_addr, exp_addr_q.pop_front(), "write address");
            check_data(mem_wr_data, exp_data_q.pop_front(), "write data");
         end
      end
      if (!rst && cmd_done) begin
         done_count++;
         if (done_count > exp_done) begin
            $display("cmd_done pulsed at %0t with no MOV outstanding", $time);
            abort_run();
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > timeout_limit) begin
         $display("Timed out after %0d cycles without the DUT finishing", cycle_count);
         $display("test failed");
         $fatal(1, "timeout");
      end
   end

   initial begin
      inst_t w;
      int    p;
      int    n;
      seed          = 72;
      cycle_count   = 0;
      timeout_limit = 200;
      done_count    = 0;
      exp_done      = 0;
      full_stage    = 0;
      full_attr     = '0;
      m_rd_base     = '0;
      m_wr_base     = '0;
      rst           = 1'b1;
      inst_wr_en    = 1'b0;
      inst_wr_data  = '0;
      peek_addr     = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // Quiet outputs with an empty FIFO
      repeat (20) begin
         @(negedge clk);
         check_flag(mem_rd_en, 1'b0, "mem_rd_en when idle");
         check_flag(mem_wr_en, 1'b0, "mem_wr_en when idle");
         check_flag(cmd_done, 1'b0, "cmd_done when idle");
         check_flag(inst_full, 1'b0, "inst_full when idle");
      end

      // Full base loads with unaligned low words followed by a copy
      load_full(ATTR_RD_BASE, region_base(2'b00));
      load_full(ATTR_WR_BASE, region_base(2'b10));
      send(make_inst(OP_MOV, 7'd3, 7'd5, 7'd2, 5'd0));
      wait_idle();

      // Partial base loads
      send(rand_inst(OP_LOAD_LOW, ATTR_RD_BASE));
      send(rand_inst(OP_LOAD_LOW, ATTR_WR_BASE));
      send(make_inst(OP_MOV, 7'd10, 7'd1, 7'd1, 5'd0));
      wait_idle();

      for (p = 0; p < PROGRAMS; p++) begin
         load_full(ATTR_RD_BASE, region_base(2'b00));
         load_full(ATTR_WR_BASE, region_base(2'b10));
         for (n = 0; n < PROGRAM_LEN; n++) begin
            send_random_inst();
         end
         send(make_inst(OP_MOV, 7'd0, 7'd0, 7'd1, 5'd0));
         wait_idle();
      end

      // Long copy holds the head while the host overfills the FIFO
      load_full(ATTR_RD_BASE, region_base(2'b00));
      load_full(ATTR_WR_BASE, region_base(2'b10));
      send(make_inst(OP_MOV, 7'd0, 7'd0, 7'd127, 5'd0));
      for (n = 0; n < INST_DEPTH + 4; n++) begin
         @(posedge clk);
         w = burst_word(n);
         inst_wr_en   <= 1'b1;
         inst_wr_data <= w;
         if (n < INST_DEPTH - 1) begin
            model_step(w);
         end else begin
            timeout_limit += 200;
         end
         @(negedge clk);
         check_flag(inst_full, n >= INST_DEPTH - 1, "inst_full behind held MOV");
      end
      @(posedge clk);
      inst_wr_en <= 1'b0;
      @(negedge clk);
      check_flag(inst_full, 1'b1, "inst_full after burst");
      wait_idle();

      foreach (model_mem[a]) begin
         peek_addr = a;
         #1;
         check_data(peek_data, model_mem[a], $sformatf("memory word at %h", a));
      end

      $display("test passed");
      $finish;
   end

endmodule

// ==== video_acc.f ====
hdl/video_acc_pkg.sv
hdl/sync_fifo.sv
hdl/inst_decoder.sv
hdl/mem_read_mover.sv
hdl/mem_write_mover.sv
hdl/video_acc.sv
bench/tb_mem.sv
bench/video_acc_tb.sv
